//--- flist.f
src/cachePkg.sv
src/cacheCtrl.sv
src/burstCounter.sv
src/wayStore.sv
src/replacePolicy.sv
src/wbCache.sv
tests/wbCacheTb.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench, status follows the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module wbCacheTb \
  -f flist.f -o wbCacheSim \
  && ./obj_dir/wbCacheSim | tee /dev/stderr | grep -q "^TESTBENCH PASSED$" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

//--- tests/wbCacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module wbCacheTb import cachePkg::*; ();

  localparam int Ways      = 4;
  localparam int NumStim   = 20;
  localparam int WaitLimit = 500;   // cycles per request

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [3:0]  byteEn;
    logic [31:0] data;
  } stimT;

  // set 3, set 13, then five tags in set 5
  localparam stimT StimTable [NumStim] = '{
    '{1'b0, 32'h0000_10C4, 4'hF, 32'h0000_0000},   // read miss
    '{1'b0, 32'h0000_10C4, 4'hF, 32'h0000_0000},   // read hit
    '{1'b1, 32'h0000_10C4, 4'h5, 32'hAABB_CCDD},   // byte write hit
    '{1'b0, 32'h0000_10C4, 4'hF, 32'h0000_0000},
    '{1'b1, 32'h0000_2348, 4'hF, 32'h1234_5678},   // write miss
    '{1'b0, 32'h0000_2348, 4'hF, 32'h0000_0000},
    '{1'b1, 32'h0000_2340, 4'h8, 32'hFE00_0000},
    '{1'b0, 32'h0000_2340, 4'hF, 32'h0000_0000},
    '{1'b0, 32'h0001_0140, 4'hF, 32'h0000_0000},   // tag A
    '{1'b1, 32'h0002_0144, 4'h3, 32'h0000_BEEF},   // tag B, dirty
    '{1'b0, 32'h0003_0148, 4'hF, 32'h0000_0000},   // tag C
    '{1'b0, 32'h0004_014C, 4'hF, 32'h0000_0000},   // tag D
    '{1'b0, 32'h0001_0140, 4'hF, 32'h0000_0000},   // A again, B now oldest
    '{1'b0, 32'h0005_0150, 4'hF, 32'h0000_0000},   // tag E evicts B
    '{1'b0, 32'h0001_0140, 4'hF, 32'h0000_0000},
    '{1'b0, 32'h0004_014C, 4'hF, 32'h0000_0000},
    '{1'b0, 32'h0003_0148, 4'hF, 32'h0000_0000},
    '{1'b0, 32'h0002_0144, 4'hF, 32'h0000_0000},   // B back from memory
    '{1'b1, 32'h0000_10C4, 4'hE, 32'h1122_3344},
    '{1'b0, 32'h0000_10C4, 4'hF, 32'h0000_0000}
  };

  logic        clk;
  logic        rst;
  cpuReqT      req;
  logic [31:0] rdata;
  logic        ok;
  logic        stall;
  busOutT      busOut;
  busInT       busIn;

  logic [31:0]        memWords [logic [29:0]];   // written-back words
  logic [7:0]         shadow [logic [31:0]];     // CPU writes by byte address
  logic [TagBits-1:0] mTag [NumSets][Ways];
  logic               mValid [NumSets][Ways];
  logic               mDirty [NumSets][Ways];
  int                 mAge [NumSets][Ways];
  logic [31:0]        lfsr;
  logic               sawRefill;
  logic               sawWriteBack;
  logic [31:0]        refillAddr;
  logic [31:0]        wbAddr;
  int                 valueErrors;
  int                 otherErrors;

  wbCache #(.NumWays(Ways)) DUT (
    .clk, .rst, .req, .rdata, .ok, .stall, .busOut, .busIn
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // memory contents and shadow
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] initWord(input logic [31:0] a);
    return (a ^ 32'h5A5A_0F0F) * 32'h9E37_79B1 + {a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] memRead(input logic [31:0] a);
    return memWords.exists(a[31:2]) ? memWords[a[31:2]] : initWord({a[31:2], 2'b00});
  endfunction

  function automatic logic [31:0] shadowWord(input logic [31:0] a);
    logic [31:0] base;
    logic [31:0] v;
    base = {a[31:2], 2'b00};
    v    = initWord(base);
    for (int b = 0; b < 4; b++) begin
      if (shadow.exists(base + b)) v[8*b +: 8] = shadow[base + b];
    end
    return v;
  endfunction

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic randomGap(output int gap);
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      gap  = (gap << 1) | int'(lfsr[0]);
      lfsr = lfsrNext(lfsr);   // one step per bit
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // LRU prediction
  //////////////////////////////////////////////////////////////////////
  task automatic touch(input int s, input int w);
    int pivot;
    pivot = mAge[s][w];
    for (int i = 0; i < Ways; i++) begin
      if (i == w) mAge[s][i] = 0;
      else if (mAge[s][i] <= pivot && mAge[s][i] < Ways - 1) mAge[s][i]++;
    end
  endtask

  task automatic modelAccess(input logic [31:0] a, input logic write, output logic hit,
                             output logic wb, output logic [31:0] wbLine);
    cacheAddrT ca;
    int        s;
    int        v;
    ca.raw = a;
    s      = int'(ca.fields.index);
    hit    = 1'b0;
    v      = -1;
    for (int i = 0; i < Ways; i++) begin
      if (mValid[s][i] && mTag[s][i] == ca.fields.tag) begin
        hit = 1'b1;
        v   = i;
      end
    end
    wb     = 1'b0;
    wbLine = '0;
    if (!hit) begin
      for (int i = Ways - 1; i >= 0; i--) begin
        if (!mValid[s][i]) v = i;   // lowest empty way
      end
      if (v < 0) begin
        v = 0;
        for (int i = 1; i < Ways; i++) begin
          if (mAge[s][i] > mAge[s][v]) v = i;
        end
      end
      wb           = mValid[s][v] && mDirty[s][v];
      wbLine       = {mTag[s][v], ca.fields.index, 6'b0};
      mTag[s][v]   = ca.fields.tag;
      mValid[s][v] = 1'b1;
      mDirty[s][v] = 1'b0;
      touch(s, v);   // fill
    end
    touch(s, v);     // completing lookup
    if (write) mDirty[s][v] = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory side of the bus
  //////////////////////////////////////////////////////////////////////
  task automatic serveBurst();
    logic        isWrite;
    logic [31:0] line;
    logic [31:0] expWord;
    int          gap;
    isWrite = busOut.memWrite;
    line    = busOut.memAddr.raw;
    if (isWrite) begin
      sawWriteBack = 1'b1;
      wbAddr       = line;
    end else begin
      sawRefill  = 1'b1;
      refillAddr = line;
    end
    randomGap(gap);
    repeat (gap) @(negedge clk);
    busIn.addrOk = 1'b1;
    @(negedge clk);
    busIn.addrOk = 1'b0;
    for (int i = 0; i < LineWords; i++) begin
      randomGap(gap);
      repeat (gap) @(negedge clk);
      busIn.dataOk = 1'b1;
      if (isWrite) begin
        expWord = shadowWord(line + 4 * i);
        assert (busOut.memWdata == expWord) else begin
          $display("[FAIL] memWdata word %0d got %h expected %h", i, busOut.memWdata, expWord);
          valueErrors++;
        end
        memWords[line[31:2] + i] = busOut.memWdata;
      end else begin
        busIn.memRdata = memRead(line + 4 * i);
      end
      @(negedge clk);
      busIn.dataOk = 1'b0;
    end
    busIn.burstDone = 1'b1;
    @(negedge clk);
    busIn.burstDone = 1'b0;
  endtask

  initial begin
    busIn = '0;
    forever begin
      @(negedge clk);
      if (busOut.memReq) serveBurst();   // memReq stays high into the refill
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////////////////////////
  initial begin
    stimT        st;
    logic        predHit;
    logic        predWb;
    logic [31:0] predWbLine;
    logic [31:0] expData;
    logic        sawMemReq;
    logic        timedOut;
    int          waited;
    clk          = 1'b0;
    rst          = 1'b1;
    req          = '0;
    lfsr         = 32'd79492;
    valueErrors  = 0;
    otherErrors  = 0;
    timedOut     = 1'b0;
    sawRefill    = 1'b0;
    sawWriteBack = 1'b0;
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < Ways; w++) begin
        mTag[s][w]   = '0;
        mValid[s][w] = 1'b0;
        mDirty[s][w] = 1'b0;
        mAge[s][w]   = 0;
      end
    end
    repeat (3) @(negedge clk);
    assert ({ok, stall, busOut.memReq, busOut.memWrite} == 4'h0) else begin
      $display("[FAIL] {ok,stall,memReq,memWrite} got %h expected 0",
               {ok, stall, busOut.memReq, busOut.memWrite});
      valueErrors++;
    end
    rst = 1'b0;

    for (int n = 0; n < NumStim && !timedOut; n++) begin
      st      = StimTable[n];
      expData = shadowWord(st.addr);
      modelAccess(st.addr, st.write, predHit, predWb, predWbLine);
      @(negedge clk);
      sawRefill    = 1'b0;
      sawWriteBack = 1'b0;
      sawMemReq    = 1'b0;
      req.valid    = 1'b1;
      req.write    = st.write;
      req.byteEn   = st.byteEn;
      req.addr.raw = st.addr;
      req.wdata    = st.data;
      waited       = 0;
      do begin
        @(negedge clk);
        waited++;
        if (busOut.memReq) sawMemReq = 1'b1;
        assert (!busOut.memReq || stall) else begin
          $display("stall is low while a memory burst is running");
          otherErrors++;
        end
      end while (!ok && waited < WaitLimit);

      if (!ok) begin
        $display("entry %0d never got ok within %0d cycles", n, WaitLimit);
        otherErrors++;
        timedOut = 1'b1;
      end else begin
        assert (sawMemReq == !predHit) else begin
          $display("entry %0d hit or missed against the LRU prediction", n);
          otherErrors++;
        end
        assert (sawRefill == !predHit) else begin
          $display("entry %0d refill presence differs from the prediction", n);
          otherErrors++;
        end
        assert (!predHit || waited == 1) else begin
          $display("entry %0d hit took %0d cycles instead of one", n, waited);
          otherErrors++;
        end
        assert (sawWriteBack == predWb) else begin
          $display("entry %0d writeback presence differs from the prediction", n);
          otherErrors++;
        end
        assert (!predWb || wbAddr == predWbLine) else begin
          $display("[FAIL] memAddr on writeback got %h expected %h", wbAddr, predWbLine);
          valueErrors++;
        end
        assert (predHit || refillAddr == {st.addr[31:6], 6'b0}) else begin
          $display("[FAIL] memAddr on refill got %h expected %h", refillAddr,
                   {st.addr[31:6], 6'b0});
          valueErrors++;
        end
        assert (st.write || rdata == expData) else begin
          $display("[FAIL] rdata at %h got %h expected %h", st.addr, rdata, expData);
          valueErrors++;
        end
        @(negedge clk);
        req.valid = 1'b0;   // back to Idle at the next edge
        if (st.write) begin
          for (int b = 0; b < 4; b++) begin
            if (st.byteEn[b]) shadow[{st.addr[31:2], 2'b00} + b] = st.data[8*b +: 8];
          end
        end
      end
    end

    $display("value errors %0d, other errors %0d", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/wbCache.sv
`timescale 1ns/1ps
`default_nettype none

module wbCache import cachePkg::*; #(
  parameter int NumWays = 4
) (
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire cpuReqT req,
  output logic [31:0] rdata,
  output logic        ok,
  output logic        stall,
  output busOutT      busOut,
  input  wire busInT  busIn
);

  localparam int WayBits = $clog2(NumWays);

  logic [NumWays-1:0]         hitVec;
  logic [NumWays-1:0]         validVec;
  logic                       victimDirty;
  logic [WayBits-1:0]         victimWay;
  logic [WayBits-1:0]         selWay;
  logic [TagBits-1:0]         victimTag;
  logic [1:0]                 busCtl;
  logic                       fillEn;
  logic                       tagWrite;
  logic                       hitWrite;
  logic                       markDirty;
  logic                       access;
  logic [WordBits:0]          count;
  logic [LineWords-1:0][31:0] lineBuf;
  logic [31:0]                wbData;
  cacheAddrT                  lineAddr;

  cacheCtrl #(.NumWays(NumWays)) ctrl (
    .clk, .rst, .req, .hitVec, .victimDirty, .victimWay,
    .burstDone(busIn.burstDone),
    .ok, .stall, .busCtl, .fillEn, .tagWrite, .hitWrite, .markDirty,
    .access, .selWay
  );

  // refill is the only burst that captures
  burstCounter counter (
    .clk, .rst,
    .active(busCtl[1]),
    .capture(busCtl[1] && !busCtl[0]),
    .busIn, .count, .lineBuf
  );

  wayStore #(.NumWays(NumWays)) store (
    .clk, .rst,
    .reqAddr(req.addr), .wdata(req.wdata), .byteEn(req.byteEn),
    .selWay, .fillEn, .tagWrite, .hitWrite, .markDirty, .lineBuf,
    .wordSel(count[WordBits-1:0]),
    .hitVec, .validVec, .rdata, .victimDirty, .victimTag, .wbData
  );

  replacePolicy #(.NumWays(NumWays)) policy (
    .clk, .rst,
    .index(req.addr.fields.index), .valid(validVec),
    .access, .accessWay(selWay), .victimWay
  );

  // victim line on writeback, request line on refill
  always_comb begin
    lineAddr.fields.tag     = busCtl[0] ? victimTag : req.addr.fields.tag;
    lineAddr.fields.index   = req.addr.fields.index;
    lineAddr.fields.word    = '0;
    lineAddr.fields.byteOff = '0;
  end

  assign busOut.memReq   = busCtl[1];
  assign busOut.memWrite = busCtl[0];
  assign busOut.memAddr  = lineAddr;
  assign busOut.memWdata = wbData;

endmodule

`default_nettype wire

//--- src/replacePolicy.sv
`timescale 1ns/1ps
`default_nettype none

module replacePolicy import cachePkg::*; #(
  parameter int  NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [IndexBits-1:0] index,
  input  wire logic [NumWays-1:0]   valid,
  input  wire logic                 access,
  input  wire logic [WayBits-1:0]   accessWay,
  output logic [WayBits-1:0]        victimWay
);

  localparam int AgeBits = WayBits;
  localparam logic [AgeBits-1:0] AgeMax = AgeBits'(NumWays - 1);

  typedef logic [NumWays-1:0][AgeBits-1:0] setAgesT;

  setAgesT            ages [NumSets];
  setAgesT            curAge;
  setAgesT            nextAge;
  logic [AgeBits-1:0] oldest;
  logic               foundFree;

  assign curAge = ages[index];

  //////////////////////////////////////////////////////////////////////
  // victim choice
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    victimWay = '0;
    foundFree = 1'b0;
    oldest    = curAge[0];
    for (int w = 0; w < NumWays; w++) begin
      if (!valid[w] && !foundFree) begin
        victimWay = WayBits'(w);   // lowest empty way first
        foundFree = 1'b1;
      end
    end
    if (!foundFree) begin
      for (int w = 1; w < NumWays; w++) begin
        if (curAge[w] > oldest) begin   // strict, ties stay low
          oldest    = curAge[w];
          victimWay = WayBits'(w);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ageing
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    nextAge = curAge;
    for (int w = 0; w < NumWays; w++) begin
      if (WayBits'(w) == accessWay) begin
        nextAge[w] = '0;
      end else if (curAge[w] <= curAge[accessWay] && curAge[w] != AgeMax) begin
        nextAge[w] = curAge[w] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int s = 0; s < NumSets; s++) ages[s] <= '0;
    end else if (access) begin
      ages[index] <= nextAge;
    end
  end

endmodule

`default_nettype wire

//--- src/wayStore.sv
`timescale 1ns/1ps
`default_nettype none

module wayStore import cachePkg::*; #(
  parameter int  NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire cacheAddrT                       reqAddr,
  input  wire logic [31:0]                     wdata,
  input  wire logic [3:0]                      byteEn,
  input  wire logic [WayBits-1:0]              selWay,
  input  wire logic                            fillEn,
  input  wire logic                            tagWrite,
  input  wire logic                            hitWrite,
  input  wire logic                            markDirty,
  input  wire logic [LineWords-1:0][31:0]      lineBuf,
  input  wire logic [WordBits-1:0]             wordSel,
  output logic [NumWays-1:0]                   hitVec,
  output logic [NumWays-1:0]                   validVec,
  output logic [31:0]                          rdata,
  output logic                                 victimDirty,
  output logic [TagBits-1:0]                   victimTag,
  output logic [31:0]                          wbData
);

  logic [TagBits-1:0]               tagMem    [NumWays][NumSets];
  logic [LineWords-1:0][31:0]       lineMem   [NumWays][NumSets];
  logic [NumSets-1:0]               validBits [NumWays];
  logic [NumSets-1:0]               dirtyBits [NumWays];

  logic [IndexBits-1:0] idx;
  logic [WordBits-1:0]  word;

  assign idx  = reqAddr.fields.index;
  assign word = reqAddr.fields.word;

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      validVec[w] = validBits[w][idx];
      hitVec[w]   = validBits[w][idx] && (tagMem[w][idx] == reqAddr.fields.tag);
    end
  end

  // hit word out
  always_comb begin
    rdata = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (hitVec[w]) rdata = lineMem[w][idx][word];
    end
  end

  // victim side, selWay holds the victim during a miss
  assign victimDirty = dirtyBits[selWay][idx];
  assign victimTag   = tagMem[selWay][idx];
  assign wbData      = lineMem[selWay][idx][wordSel];

  //////////////////////////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int w = 0; w < NumWays; w++) begin
        validBits[w] <= '0;
        dirtyBits[w] <= '0;
      end
    end else if (fillEn) begin
      validBits[selWay][idx] <= 1'b1;
      dirtyBits[selWay][idx] <= 1'b0;   // fresh line matches memory
    end else if (markDirty) begin
      dirtyBits[selWay][idx] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tags and lines
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (tagWrite) tagMem[selWay][idx] <= reqAddr.fields.tag;
    if (fillEn) begin
      lineMem[selWay][idx] <= lineBuf;
    end else if (hitWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (byteEn[b]) lineMem[selWay][idx][word][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/burstCounter.sv
`timescale 1ns/1ps
`default_nettype none

module burstCounter import cachePkg::*; (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            active,    // any burst in flight
  input  wire logic                            capture,   // refill burst
  input  wire busInT                           busIn,
  output logic [WordBits:0]                    count,
  output logic [LineWords-1:0][31:0]           lineBuf
);

  logic [WordBits-1:0] slot;

  assign slot = count[WordBits-1:0];

  // word count, restarts on addrOk
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (!active || busIn.addrOk) begin
      count <= '0;
    end else if (busIn.dataOk) begin
      count <= count + 1'b1;
    end
  end

  // refill staging
  always_ff @(posedge clk) begin
    if (active && capture && busIn.dataOk) begin
      lineBuf[slot] <= busIn.memRdata;
    end
  end

  // memory sends exactly one line per burst
  countInRange: assert property (@(posedge clk) disable iff (rst)
    count <= LineWords);

endmodule

`default_nettype wire

//--- src/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl import cachePkg::*; #(
  parameter int  NumWays = 4,
  localparam int WayBits = $clog2(NumWays)
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire cpuReqT             req,
  input  wire logic [NumWays-1:0] hitVec,
  input  wire logic               victimDirty,
  input  wire logic [WayBits-1:0] victimWay,
  input  wire logic               burstDone,
  output logic                    ok,
  output logic                    stall,
  output logic [1:0]              busCtl,     // {memReq, memWrite}
  output logic                    fillEn,
  output logic                    tagWrite,
  output logic                    hitWrite,
  output logic                    markDirty,
  output logic                    access,
  output logic [WayBits-1:0]      selWay
);

  ctrlStateT          state;
  ctrlStateT          nextState;
  logic [WayBits-1:0] missWay;   // victim held over the whole miss
  logic [WayBits-1:0] hitWay;
  logic               hit;

  assign hit = |hitVec;

  always_comb begin
    hitWay = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (hitVec[w]) hitWay = WayBits'(w);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= Idle;
      missWay <= '0;
    end else begin
      state <= nextState;
      if (state == Lookup && req.valid && !hit) missWay <= victimWay;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state and strobes
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    nextState = state;
    ok        = 1'b0;
    busCtl    = 2'b00;
    fillEn    = 1'b0;
    tagWrite  = 1'b0;
    hitWrite  = 1'b0;
    markDirty = 1'b0;
    access    = 1'b0;
    selWay    = missWay;
    case (state)
      Idle: begin
        if (req.valid) nextState = Lookup;
      end
      Lookup: begin
        if (!req.valid) begin
          nextState = Idle;
        end else if (hit) begin
          ok        = 1'b1;
          access    = 1'b1;
          selWay    = hitWay;
          hitWrite  = req.write;   // byte merge commits at this edge
          markDirty = req.write;
          nextState = Lookup;
        end else begin
          selWay    = victimWay;   // victim flags read through selWay
          nextState = victimDirty ? WriteBack : Refill;
        end
      end
      WriteBack: begin
        busCtl = 2'b11;
        if (burstDone) nextState = Refill;
      end
      Refill: begin
        busCtl = 2'b10;
        if (burstDone) nextState = Fill;
      end
      Fill: begin
        fillEn    = 1'b1;
        tagWrite  = 1'b1;
        access    = 1'b1;
        nextState = Lookup;   // request then hits in the new line
      end
      default: nextState = Idle;
    endcase
  end

  assign stall = (state == WriteBack) || (state == Refill) || (state == Fill);

  // pipeline never sees a completion while stalled
  okNotStalled: assert property (@(posedge clk) disable iff (rst)
    !(ok && stall));

  // tags of one set stay unique across the ways
  hitOneHot: assert property (@(posedge clk) disable iff (rst)
    (state == Lookup) |-> $onehot0(hitVec));

endmodule

`default_nettype wire

//--- src/cachePkg.sv
`default_nettype none

package cachePkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////
  parameter int AddrBits  = 32;
  parameter int ByteBits  = 2;
  parameter int WordBits  = 4;   // 16 words per line
  parameter int IndexBits = 4;   // 16 sets
  parameter int TagBits   = AddrBits - IndexBits - WordBits - ByteBits;
  parameter int LineWords = 1 << WordBits;
  parameter int NumSets   = 1 << IndexBits;

  // one address word, seen as a bus address or split into fields
  typedef union packed {
    logic [AddrBits-1:0] raw;
    struct packed {
      logic [TagBits-1:0]   tag;
      logic [IndexBits-1:0] index;
      logic [WordBits-1:0]  word;
      logic [ByteBits-1:0]  byteOff;
    } fields;
  } cacheAddrT;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  byteEn;
    cacheAddrT   addr;
    logic [31:0] wdata;
  } cpuReqT;

  // toward memory
  typedef struct packed {
    logic        memReq;    // level, held for the whole burst
    logic        memWrite;
    cacheAddrT   memAddr;   // line aligned
    logic [31:0] memWdata;
  } busOutT;

  // from memory, all three strobes are single-cycle pulses
  typedef struct packed {
    logic        addrOk;
    logic        dataOk;
    logic        burstDone;
    logic [31:0] memRdata;
  } busInT;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    Refill,
    Fill
  } ctrlStateT;

endpackage

`default_nettype wire
